//--- design/lsuPkg.sv
/*
  LSU package
  Shared widths and encodings for the load/store unit. It names the
  request kind, the RISC-V funct3 style access size and the states of
  the control FSM.
*/

package lsuPkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // data and address width of the core and of the memory bus
  localparam int XLEN = 32;

  // byte lanes in one bus word
  localparam int BYTES_PER_WORD = XLEN / 8;

  // byte offset inside a word, log2 of the lane count
  localparam int OFFSET_BITS = 2;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // kind of memory request coming from the core
  typedef enum logic [1:0] {
    opLoad  = 2'd0,
    opStore = 2'd1,
    opLr    = 2'd2,
    opSc    = 2'd3
  } lsuOpE;

  // access size as in funct3
  // bits 1:0 give the size and bit 2 asks for zero extension on loads
  typedef enum logic [2:0] {
    szByte  = 3'd0,
    szHalf  = 3'd1,
    szWord  = 3'd2,
    szByteU = 3'd4,
    szHalfU = 3'd5
  } memSizeE;

  // request FSM
  // stBus covers both the bus access and the response of a skipped request
  typedef enum logic [1:0] {
    stIdle = 2'd0,
    stBus  = 2'd1,
    stResp = 2'd2
  } ctrlStateE;

endpackage

//--- design/storeFormat.sv
/*
  Store formatter
  Spreads the byte or halfword of the store across the bus word, builds
  the byte strobes from size and offset, and swaps both into big-endian
  lane order when the core asks for it.
*/

`timescale 1ns/1ps

module storeFormat (
  input  lsuPkg::memSizeE                     curSize,
  input  logic [lsuPkg::OFFSET_BITS-1:0]      curOffset,
  input  logic [lsuPkg::XLEN-1:0]             curWdata,
  input  logic                                curBigEndian,
  output logic [lsuPkg::XLEN-1:0]             busWdata,
  output logic [lsuPkg::BYTES_PER_WORD-1:0]   busStrb
);

  // little-endian view of the write before any byte swap
  logic [lsuPkg::XLEN-1:0]            leData;
  logic [lsuPkg::BYTES_PER_WORD-1:0]  leStrb;

  ////////////////////////////////////////////////////////////
  // replication and strobes
  ////////////////////////////////////////////////////////////

  // the value is copied into every lane so the strobe alone picks the target
  always_comb begin
    case (curSize)
      lsuPkg::szByte, lsuPkg::szByteU: begin
        leData = {lsuPkg::BYTES_PER_WORD{curWdata[7:0]}};
        leStrb = {{(lsuPkg::BYTES_PER_WORD-1){1'b0}}, 1'b1} << curOffset;
      end
      lsuPkg::szHalf, lsuPkg::szHalfU: begin
        leData = {(lsuPkg::BYTES_PER_WORD/2){curWdata[15:0]}};
        leStrb = {{(lsuPkg::BYTES_PER_WORD-2){1'b0}}, 2'b11} << curOffset;
      end
      default: begin
        leData = curWdata;
        leStrb = '1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // endian swap
  ////////////////////////////////////////////////////////////

  // big endian puts the byte at offset k into lane 3-k
  always_comb begin
    for (int i = 0; i < lsuPkg::BYTES_PER_WORD; i++) begin
      if (curBigEndian) begin
        busWdata[8*i +: 8] = leData[8*(lsuPkg::BYTES_PER_WORD-1-i) +: 8];
        busStrb[i]         = leStrb[lsuPkg::BYTES_PER_WORD-1-i];
      end else begin
        busWdata[8*i +: 8] = leData[8*i +: 8];
        busStrb[i]         = leStrb[i];
      end
    end
  end

endmodule

//--- design/loadFormat.sv
/*
  Load formatter
  Brings the bus word back into little-endian order, picks the byte or
  halfword at the request offset and sign- or zero-extends it to the
  full register width.
*/

`timescale 1ns/1ps

module loadFormat (
  input  logic [lsuPkg::XLEN-1:0]             busRdata,
  input  lsuPkg::memSizeE                     curSize,
  input  logic [lsuPkg::OFFSET_BITS-1:0]      curOffset,
  input  logic                                curBigEndian,
  output logic [lsuPkg::XLEN-1:0]             loadData
);

  logic [lsuPkg::XLEN-1:0]  leWord;
  logic [lsuPkg::XLEN-1:0]  shifted;
  logic                     signBit;

  ////////////////////////////////////////////////////////////
  // endian swap and lane select
  ////////////////////////////////////////////////////////////

  // same lane mapping as the store side so a round trip is transparent
  always_comb begin
    for (int i = 0; i < lsuPkg::BYTES_PER_WORD; i++) begin
      if (curBigEndian) leWord[8*i +: 8] = busRdata[8*(lsuPkg::BYTES_PER_WORD-1-i) +: 8];
      else leWord[8*i +: 8] = busRdata[8*i +: 8];
    end
  end

  // shift the addressed byte down to lane 0
  assign shifted = leWord >> {curOffset, 3'b000};

  ////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////

  // bit 2 of the size code asks for zero extension
  always_comb begin
    case (curSize)
      lsuPkg::szByte: signBit = shifted[7];
      lsuPkg::szHalf: signBit = shifted[15];
      default:        signBit = 1'b0;
    endcase
  end

  always_comb begin
    case (curSize)
      lsuPkg::szByte, lsuPkg::szByteU: begin
        loadData = {{(lsuPkg::XLEN-8){signBit}}, shifted[7:0]};
      end
      lsuPkg::szHalf, lsuPkg::szHalfU: begin
        loadData = {{(lsuPkg::XLEN-16){signBit}}, shifted[15:0]};
      end
      default: loadData = shifted;
    endcase
  end

endmodule

//--- design/reservation.sv
/*
  LR/SC reservation
  Remembers the word reserved by the last load-reserved and tells the
  controller whether a store-conditional to the current word may go.
*/

`timescale 1ns/1ps

module reservation (
  input  logic                     clk,
  input  logic                     rst,
  input  lsuPkg::lsuOpE            curOp,
  input  logic [lsuPkg::XLEN-1:0]  busAddr,
  input  logic                     resvUpdate,
  output logic                     scPass
);

  logic                     resvValid;
  logic [lsuPkg::XLEN-1:0]  resvAddr;

  // busAddr is already word aligned so a full compare matches the word
  assign scPass = resvValid & (resvAddr == busAddr);

  // LR sets, any SC clears, and a plain store to the reserved word clears
  always_ff @(posedge clk) begin
    if (rst) begin
      resvValid <= 1'b0;
    end else if (resvUpdate) begin
      case (curOp)
        lsuPkg::opLr:    resvValid <= 1'b1;
        lsuPkg::opSc:    resvValid <= 1'b0;
        lsuPkg::opStore: if (scPass) resvValid <= 1'b0;
        default:         resvValid <= resvValid;
      endcase
    end
  end

  // LR records the word address that it reserves
  always_ff @(posedge clk) begin
    if (resvUpdate && curOp == lsuPkg::opLr) begin
      resvAddr <= busAddr;
    end
  end

endmodule

//--- design/lsuCtrl.sv
/*
  LSU request controller
  Accepts a core request, registers it, flags misaligned accesses and
  sequences one bus beat. Faulting requests and failed store-conditionals
  answer without touching the bus. The response is held until the core
  takes it, and only then is a new request accepted.
*/

`timescale 1ns/1ps

module lsuCtrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                reqValid,
  output logic                                reqReady,
  input  lsuPkg::lsuOpE                       reqOp,
  input  lsuPkg::memSizeE                     reqSize,
  input  logic [lsuPkg::XLEN-1:0]             reqAddr,
  input  logic [lsuPkg::XLEN-1:0]             reqWdata,
  input  logic                                bigEndian,
  output logic                                rspValid,
  input  logic                                rspReady,
  output logic [lsuPkg::XLEN-1:0]             rspData,
  output logic                                rspFault,
  output logic                                busValid,
  input  logic                                busReady,
  output logic                                busWrite,
  output logic [lsuPkg::XLEN-1:0]             busAddr,
  output lsuPkg::lsuOpE                       curOp,
  output lsuPkg::memSizeE                     curSize,
  output logic [lsuPkg::OFFSET_BITS-1:0]      curOffset,
  output logic [lsuPkg::XLEN-1:0]             curWdata,
  output logic                                curBigEndian,
  input  logic [lsuPkg::XLEN-1:0]             loadData,
  input  logic                                scPass,
  output logic                                resvUpdate
);

  lsuPkg::ctrlStateE                          state;
  logic [lsuPkg::XLEN-1:lsuPkg::OFFSET_BITS]  curWordAddr;
  logic                                       curFault;
  logic [lsuPkg::XLEN-1:0]                    rspReg;
  logic                                       accept;
  logic                                       reqMisaligned;
  logic                                       scFail;
  logic                                       skipBus;
  logic                                       busDone;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////

  assign reqReady = (state == lsuPkg::stIdle);
  assign accept   = reqValid & reqReady;

  // halfwords need an even offset and words a zero offset
  always_comb begin
    case (reqSize)
      lsuPkg::szHalf, lsuPkg::szHalfU: reqMisaligned = reqAddr[0];
      lsuPkg::szWord:                  reqMisaligned = |reqAddr[lsuPkg::OFFSET_BITS-1:0];
      default:                         reqMisaligned = 1'b0;
    endcase
  end

  // payload of the request, only meaningful after an accept
  always_ff @(posedge clk) begin
    if (accept) begin
      curOp        <= reqOp;
      curSize      <= reqSize;
      curOffset    <= reqAddr[lsuPkg::OFFSET_BITS-1:0];
      curWordAddr  <= reqAddr[lsuPkg::XLEN-1:lsuPkg::OFFSET_BITS];
      curWdata     <= reqWdata;
      curBigEndian <= bigEndian;
    end
  end

  // misalignment of the accepted request, reported on rspFault
  always_ff @(posedge clk) begin
    if (rst) begin
      curFault <= 1'b0;
    end else if (accept) begin
      curFault <= reqMisaligned;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus sequencing
  ////////////////////////////////////////////////////////////

  // an SC whose reservation is gone answers 1 without a bus beat
  assign scFail  = (curOp == lsuPkg::opSc) & ~scPass & ~curFault;
  assign skipBus = curFault | scFail;

  assign busValid = (state == lsuPkg::stBus) & ~skipBus;
  assign busDone  = busValid & busReady;
  assign busWrite = (curOp == lsuPkg::opStore) | ((curOp == lsuPkg::opSc) & scPass);
  assign busAddr  = {curWordAddr, {lsuPkg::OFFSET_BITS{1'b0}}};

  // reservation sees the end of every good access, bus or not
  assign resvUpdate = busDone | ((state == lsuPkg::stBus) & scFail & rspReady);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lsuPkg::stIdle;
    end else begin
      case (state)
        lsuPkg::stIdle: begin
          if (accept) state <= lsuPkg::stBus;
        end
        lsuPkg::stBus: begin
          // skipped requests leave straight from here once the core takes the answer
          if (skipBus) begin
            if (rspReady) state <= lsuPkg::stIdle;
          end else if (busReady) begin
            state <= lsuPkg::stResp;
          end
        end
        lsuPkg::stResp: begin
          if (rspReady) state <= lsuPkg::stIdle;
        end
        default: state <= lsuPkg::stIdle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  // loads and LR return data, a stored word or a good SC returns zero
  always_ff @(posedge clk) begin
    if (busDone) begin
      if (curOp == lsuPkg::opLoad || curOp == lsuPkg::opLr) rspReg <= loadData;
      else rspReg <= '0;
    end
  end

  assign rspValid = (state == lsuPkg::stResp) | ((state == lsuPkg::stBus) & skipBus);
  assign rspFault = curFault;
  assign rspData  = (state == lsuPkg::stBus) ? {{(lsuPkg::XLEN-1){1'b0}}, scFail} : rspReg;

endmodule

//--- design/lsu.sv
/*
  Load/store unit, top level
  Takes one memory request at a time from the core, checks alignment,
  formats store data and strobes, runs a single beat on the memory bus
  and hands back extended load data or the store-conditional status.
*/

`timescale 1ns/1ps

module lsu (
  input  logic                                clk,
  input  logic                                rst,
  // core request
  input  logic                                reqValid,
  output logic                                reqReady,
  input  lsuPkg::lsuOpE                       reqOp,
  input  lsuPkg::memSizeE                     reqSize,
  input  logic [lsuPkg::XLEN-1:0]             reqAddr,
  input  logic [lsuPkg::XLEN-1:0]             reqWdata,
  input  logic                                bigEndian,
  // core response
  output logic                                rspValid,
  input  logic                                rspReady,
  output logic [lsuPkg::XLEN-1:0]             rspData,
  output logic                                rspFault,
  // memory bus
  output logic                                busValid,
  input  logic                                busReady,
  output logic                                busWrite,
  output logic [lsuPkg::XLEN-1:0]             busAddr,
  output logic [lsuPkg::BYTES_PER_WORD-1:0]   busStrb,
  output logic [lsuPkg::XLEN-1:0]             busWdata,
  input  logic [lsuPkg::XLEN-1:0]             busRdata
);

  // registered request held by the controller for the whole access
  lsuPkg::lsuOpE                   curOp;
  lsuPkg::memSizeE                 curSize;
  logic [lsuPkg::OFFSET_BITS-1:0]  curOffset;
  logic [lsuPkg::XLEN-1:0]         curWdata;
  logic                            curBigEndian;

  // datapath results back into the controller
  logic [lsuPkg::XLEN-1:0]         loadData;
  logic                            scPass;
  logic                            resvUpdate;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  lsuCtrl ctrl (
    .clk, .rst,
    .reqValid, .reqReady, .reqOp, .reqSize, .reqAddr, .reqWdata, .bigEndian,
    .rspValid, .rspReady, .rspData, .rspFault,
    .busValid, .busReady, .busWrite, .busAddr,
    .curOp, .curSize, .curOffset, .curWdata, .curBigEndian,
    .loadData, .scPass, .resvUpdate
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  // store side builds the bus word and its strobes
  storeFormat storeFmt (
    .curSize, .curOffset, .curWdata, .curBigEndian,
    .busWdata, .busStrb
  );

  // load side turns the bus word into the value for the core
  loadFormat loadFmt (
    .busRdata, .curSize, .curOffset, .curBigEndian,
    .loadData
  );

  // LR/SC reservation works on the word-aligned bus address
  reservation resv (
    .clk, .rst,
    .curOp, .busAddr, .resvUpdate,
    .scPass
  );

endmodule

//--- bench/lsuModel.svh
/*
  LSU reference model
  Random source, bus-side memory, shadow memory and the functions that
  predict strobes, store data and extended load values from the
  size, offset and byte-order rules of the load/store unit.
*/

`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

localparam int MEM_WORDS = 256;

// memory seen by the bus responder, written under busStrb
logic [31:0] busMem [MEM_WORDS];
// shadow memory updated by the reference rules only
logic [31:0] shadowMem [MEM_WORDS];

// one step of a 32-bit linear congruential generator
function automatic logic [31:0] lcgNext(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// fill value that depends on every bit of the word index
function automatic logic [31:0] fillWord(input int idx);
  return (idx * 32'h9E3779B1) ^ 32'h5A5A0000 ^ (idx << 20);
endfunction

// bus lane that carries the byte at word offset k
function automatic int laneOf(input int k, input logic be);
  return be ? 3 - k : k;
endfunction

function automatic int sizeBytes(input lsuPkg::memSizeE s);
  case (s)
    lsuPkg::szByte, lsuPkg::szByteU: return 1;
    lsuPkg::szHalf, lsuPkg::szHalfU: return 2;
    default:                         return 4;
  endcase
endfunction

function automatic logic [3:0] expectedStrb(input lsuPkg::memSizeE s, input int off,
                                            input logic be);
  logic [3:0] strb;
  strb = '0;
  for (int j = 0; j < sizeBytes(s); j++) strb[laneOf(off + j, be)] = 1'b1;
  return strb;
endfunction

// datum byte j goes to the lane of offset off+j
function automatic logic [31:0] expectedWdata(input lsuPkg::memSizeE s, input int off,
                                              input logic [31:0] wd, input logic be);
  logic [31:0] w;
  w = '0;
  for (int j = 0; j < sizeBytes(s); j++) w[8*laneOf(off + j, be) +: 8] = wd[8*j +: 8];
  return w;
endfunction

function automatic logic [31:0] expectedLoad(input logic [31:0] word,
                                             input lsuPkg::memSizeE s, input int off,
                                             input logic be);
  logic [31:0] v;
  v = '0;
  for (int j = 0; j < sizeBytes(s); j++) v[8*j +: 8] = word[8*laneOf(off + j, be) +: 8];
  if (s == lsuPkg::szByte) v = {{24{v[7]}}, v[7:0]};
  if (s == lsuPkg::szHalf) v = {{16{v[15]}}, v[15:0]};
  return v;
endfunction

`endif

//--- bench/lsuTb.sv
/*
  LSU testbench
  Drives requests into the load/store unit, answers its bus with a
  random-latency memory and compares every response and bus write with
  the reference model.
*/

`timescale 1ns/1ps

module lsuTb;

  `include "lsuModel.svh"

  localparam int WAIT_LIMIT = 400;

  logic clk, rst, reqValid, reqReady, bigEndian, rspValid, rspReady, rspFault;
  logic busValid, busReady, busWrite;
  lsuPkg::lsuOpE reqOp;
  lsuPkg::memSizeE reqSize;
  logic [31:0] reqAddr, reqWdata, rspData, busAddr, busWdata, busRdata;
  logic [3:0] busStrb;

  // expected responses in request order, plus the bus view of the item in flight
  logic [31:0] expData[$];
  logic expFault[$];
  logic noBus, expWrite, bpMode, resvValid, prevHeld;
  logic [31:0] expAddr, expWdata, resvAddr, prevData, stimSeed, busSeed, rspSeed;
  logic [3:0] expStrb;
  int errors = 0;
  int checks = 0;

  lsu DUT (.*);

  assign busRdata = busMem[busAddr[9:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic timeoutFail(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic nextRand(output logic [31:0] v);
    stimSeed = lcgNext(stimSeed);
    v[31:16] = stimSeed[31:16];
    stimSeed = lcgNext(stimSeed);
    v[15:0] = stimSeed[31:16];
  endtask

  ////////////////////////////////////////////////////////////
  // bus responder and compare process
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    busSeed = lcgNext(busSeed);
    rspSeed = lcgNext(rspSeed);
    busReady = busSeed[30:29] != 2'b00;
    rspReady = bpMode ? rspSeed[30] : 1'b1;
  end

  always @(posedge clk) begin
    // a skipped request keeps busValid low from acceptance to response
    if (!rst && busValid) begin
      assert (!noBus) else begin
        $display("bus request at %0t for a request that must skip the bus", $time);
        errors++;
      end
    end
    if (!rst && busValid && busReady) begin
      assert (busWrite == expWrite && busAddr == expAddr) else begin
        $display("CHECK FAILED t=%0t busWrite/busAddr got %b/%h exp %b/%h",
                 $time, busWrite, busAddr, expWrite, expAddr);
        errors++;
      end
      if (busWrite) begin
        assert (busStrb == expStrb) else begin
          $display("CHECK FAILED t=%0t busStrb got %b exp %b", $time, busStrb, expStrb);
          errors++;
        end
        for (int i = 0; i < 4; i++) begin
          if (busStrb[i]) begin
            assert (busWdata[8*i +: 8] == expWdata[8*i +: 8]) else begin
              $display("CHECK FAILED t=%0t busWdata got %h exp %h", $time, busWdata, expWdata);
              errors++;
            end
            busMem[busAddr[9:2]][8*i +: 8] = busWdata[8*i +: 8];
          end
        end
      end
      checks++;
    end
  end

  always @(posedge clk) begin
    if (!rst && prevHeld && rspValid) begin
      assert (rspData == prevData) else begin
        $display("CHECK FAILED t=%0t rspData held got %h exp %h", $time, rspData, prevData);
        errors++;
      end
    end
    if (!rst && rspValid && rspReady) begin
      if (expData.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        errors++;
      end else begin
        assert (rspData == expData[0] && rspFault == expFault[0]) else begin
          $display("CHECK FAILED t=%0t rspData/rspFault got %h/%b exp %h/%b",
                   $time, rspData, rspFault, expData[0], expFault[0]);
          errors++;
        end
        void'(expData.pop_front());
        void'(expFault.pop_front());
        checks++;
      end
    end
    prevHeld = rspValid && !rspReady;
    prevData = rspData;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // predicts the result from the shadow memory, then hands the request over
  task automatic issue(input lsuPkg::lsuOpE op, input lsuPkg::memSizeE sz,
                       input logic [31:0] addr, input logic [31:0] wd, input logic be);
    int cnt;
    int off;
    logic misal;
    logic match;
    cnt = 0;
    while (!reqReady) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) timeoutFail("reqReady");
    end
    off = int'(addr[1:0]);
    misal = (sizeBytes(sz) == 2 && addr[0]) || (sizeBytes(sz) == 4 && addr[1:0] != 2'b00);
    match = resvValid && resvAddr == {addr[31:2], 2'b00};
    noBus = 1'b1;
    expWrite = 1'b0;
    expAddr = {addr[31:2], 2'b00};
    expStrb = expectedStrb(sz, off, be);
    expWdata = expectedWdata(sz, off, wd, be);
    if (misal) begin
      expData.push_back(32'd0);
      expFault.push_back(1'b1);
    end else begin
      expFault.push_back(1'b0);
      if (op == lsuPkg::opLoad || op == lsuPkg::opLr) begin
        noBus = 1'b0;
        expData.push_back(expectedLoad(shadowMem[addr[9:2]], sz, off, be));
      end else if (op == lsuPkg::opStore || match) begin
        noBus = 1'b0;
        expWrite = 1'b1;
        expData.push_back(32'd0);
        for (int i = 0; i < 4; i++)
          if (expStrb[i]) shadowMem[addr[9:2]][8*i +: 8] = expWdata[8*i +: 8];
      end else begin
        expData.push_back(32'd1);
      end
      // LR sets the reservation, SC and a store to the reserved word clear it
      if (op == lsuPkg::opLr) resvAddr = expAddr;
      if (op == lsuPkg::opLr) resvValid = 1'b1;
      else if (op == lsuPkg::opSc || (op == lsuPkg::opStore && match)) resvValid = 1'b0;
    end
    reqOp = op;
    reqSize = sz;
    reqAddr = addr;
    reqWdata = wd;
    bigEndian = be;
    reqValid = 1'b1;
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic finishTest(input string name, input int errStart);
    int cnt;
    cnt = 0;
    while (expData.size() != 0 || !reqReady) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) timeoutFail({"responses of test ", name});
    end
    $display("test %s done with %0d errors", name, errors - errStart);
  endtask

  // byte and halfword stores and loads at every legal offset
  task automatic subwordRound(input logic [31:0] base, input logic be);
    logic [31:0] v;
    for (int off = 0; off < 4; off++) begin
      nextRand(v);
      issue(lsuPkg::opStore, lsuPkg::szByte, base + off, v, be);
      issue(lsuPkg::opLoad, lsuPkg::szByte, base + off, 0, be);
      issue(lsuPkg::opLoad, lsuPkg::szByteU, base + off, 0, be);
      if (off % 2 == 0) begin
        issue(lsuPkg::opStore, lsuPkg::szHalf, base + off, v ^ 32'h8000, be);
        issue(lsuPkg::opLoad, lsuPkg::szHalf, base + off, 0, be);
        issue(lsuPkg::opLoad, lsuPkg::szHalfU, base + off, 0, be);
      end
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] addrs[$];
    int e;
    int cnt;
    lsuPkg::memSizeE sz;
    for (int i = 0; i < MEM_WORDS; i++) begin
      busMem[i] = fillWord(i);
      shadowMem[i] = fillWord(i);
    end
    stimSeed = 32'd52487;
    busSeed = lcgNext(stimSeed);
    rspSeed = lcgNext(busSeed);
    rst = 1'b1;
    reqValid = 1'b0;
    reqOp = lsuPkg::opLoad;
    reqSize = lsuPkg::szWord;
    reqAddr = '0;
    reqWdata = '0;
    bigEndian = 1'b0;
    rspReady = 1'b1;
    busReady = 1'b0;
    bpMode = 1'b0;
    noBus = 1'b1;
    expWrite = 1'b0;
    resvValid = 1'b0;
    prevHeld = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    assert (reqReady && !busValid && !rspValid) else begin
      $display("CHECK FAILED t=%0t reqReady/busValid/rspValid got %b/%b/%b exp 1/0/0",
               $time, reqReady, busValid, rspValid);
      errors++;
    end

    e = errors;
    for (int i = 0; i < 16; i++) begin
      nextRand(v);
      addrs.push_back({22'd0, v[9:2], 2'b00});
      nextRand(v);
      issue(lsuPkg::opStore, lsuPkg::szWord, addrs[i], v, 1'b0);
    end
    foreach (addrs[i]) issue(lsuPkg::opLoad, lsuPkg::szWord, addrs[i], 0, 1'b0);
    finishTest("word access", e);

    e = errors;
    subwordRound(32'h40, 1'b0);
    finishTest("subword access", e);

    e = errors;
    subwordRound(32'h80, 1'b1);
    nextRand(v);
    issue(lsuPkg::opStore, lsuPkg::szWord, 32'h90, v, 1'b1);
    issue(lsuPkg::opLoad, lsuPkg::szWord, 32'h90, 0, 1'b0);
    issue(lsuPkg::opLoad, lsuPkg::szWord, 32'h90, 0, 1'b1);
    finishTest("big-endian mode", e);

    e = errors;
    issue(lsuPkg::opLoad, lsuPkg::szHalf, 32'hA1, 0, 1'b0);
    issue(lsuPkg::opStore, lsuPkg::szHalfU, 32'hA3, 32'h1234, 1'b0);
    for (int off = 1; off < 4; off++) begin
      issue(lsuPkg::opLoad, lsuPkg::szWord, 32'hA4 + off, 0, 1'b0);
      issue(lsuPkg::opStore, lsuPkg::szWord, 32'hA4 + off, 32'hDEADBEEF, 1'b1);
    end
    finishTest("misalignment", e);

    e = errors;
    issue(lsuPkg::opSc, lsuPkg::szWord, 32'h100, 32'h11, 1'b0);
    issue(lsuPkg::opLr, lsuPkg::szWord, 32'h100, 0, 1'b0);
    issue(lsuPkg::opSc, lsuPkg::szWord, 32'h100, 32'hCAFE0001, 1'b0);
    issue(lsuPkg::opLoad, lsuPkg::szWord, 32'h100, 0, 1'b0);
    issue(lsuPkg::opSc, lsuPkg::szWord, 32'h100, 32'h22, 1'b0);
    issue(lsuPkg::opLr, lsuPkg::szWord, 32'h100, 0, 1'b0);
    issue(lsuPkg::opStore, lsuPkg::szByte, 32'h102, 32'h77, 1'b0);
    issue(lsuPkg::opSc, lsuPkg::szWord, 32'h100, 32'h33, 1'b0);
    issue(lsuPkg::opLoad, lsuPkg::szWord, 32'h100, 0, 1'b0);
    finishTest("lr/sc", e);

    e = errors;
    bpMode = 1'b1;
    for (int i = 0; i < 48; i++) begin
      nextRand(v);
      case (v[2:0])
        3'd0: sz = lsuPkg::szByte;
        3'd1: sz = lsuPkg::szHalf;
        3'd2: sz = lsuPkg::szByteU;
        3'd3: sz = lsuPkg::szHalfU;
        default: sz = lsuPkg::szWord;
      endcase
      issue(v[3] ? lsuPkg::opStore : lsuPkg::opLoad, sz, {22'd0, v[13:4]}, ~v, v[14]);
    end
    finishTest("back-pressure", e);

    // let the last bus and response cycles settle before the summary
    cnt = 0;
    while (cnt < 3) begin
      @(negedge clk);
      cnt++;
    end
    $display("summary: %0d checks, %0d failures", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- lsu.f
design/lsuPkg.sv
design/storeFormat.sv
design/loadFormat.sv
design/reservation.sv
design/lsuCtrl.sv
design/lsu.sv
+incdir+bench
bench/lsuTb.sv

//--- runSim.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and look for the pass message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing \
  -f lsu.f \
  --top-module lsuTb \
  -o lsuSim

# keep the run log so the result can be searched afterwards
./obj_dir/lsuSim | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
